/* include/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// data path
`define XLEN       32

// architectural registers
`define ARCH_REGS  32
`define AREG_W     5

// physical registers, x0 maps to p0 for good
`define PHYS_REGS  64
`define PREG_W     6

// reorder buffer
`define ROB_DEPTH  16
`define ROB_W      4

`endif

/* hw/ooo_pkg.sv */
`default_nettype none

`include "ooo_defines.svh"

package ooo_pkg;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOP
    } alu_op_e;

    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic               use_imm;
        logic [`AREG_W-1:0] rs1;
        logic [`AREG_W-1:0] rs2;
        logic [`AREG_W-1:0] rd;
        logic [`XLEN-1:0]   imm;   // already sign-extended
    } arch_uop_t;

    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic               use_imm;
        logic [`XLEN-1:0]   imm;
        logic [`PREG_W-1:0] prs1;
        logic [`PREG_W-1:0] prs2;
        logic [`PREG_W-1:0] prd;
        logic [`AREG_W-1:0] ard;
        logic [`PREG_W-1:0] old_prd;   // freed when this retires
        logic [`ROB_W-1:0]  tag;
    } phys_uop_t;

    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] prd;
        logic [`ROB_W-1:0]  tag;
        logic [`XLEN-1:0]   value;
    } wb_t;

    typedef struct packed {
        logic               valid;
        logic [`AREG_W-1:0] rd;
        logic [`PREG_W-1:0] old_prd;
        logic [`XLEN-1:0]   value;
    } retire_t;

endpackage

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module decode (
    input  wire logic [31:0]       instr,
    input  wire logic              instr_valid,
    output ooo_pkg::arch_uop_t     uop
);

    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`AREG_W-1:0] rd;
    ooo_pkg::alu_op_e   op;
    logic               use_imm;
    logic               writes_reg;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    always_comb begin
        op      = ooo_pkg::ALU_NOP;
        use_imm = 1'b0;
        if (instr[6:0] == ooo_pkg::OPC_OP) begin
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: op = ooo_pkg::ALU_ADD;
                {7'b0100000, 3'b000}: op = ooo_pkg::ALU_SUB;
                {7'b0000000, 3'b100}: op = ooo_pkg::ALU_XOR;
                {7'b0000000, 3'b110}: op = ooo_pkg::ALU_OR;
                {7'b0000000, 3'b111}: op = ooo_pkg::ALU_AND;
                default:              op = ooo_pkg::ALU_NOP;
            endcase
        end else if (instr[6:0] == ooo_pkg::OPC_OP_IMM && funct3 == 3'b000) begin
            op      = ooo_pkg::ALU_ADD;   // addi
            use_imm = 1'b1;
        end
    end

    // a write to x0 does nothing, so it goes down as a nop with no sources
    assign writes_reg = (op != ooo_pkg::ALU_NOP) && (rd != '0);

    always_comb begin
        uop.valid   = instr_valid;
        uop.op      = writes_reg ? op : ooo_pkg::ALU_NOP;
        uop.use_imm = writes_reg & use_imm;
        uop.rs1     = writes_reg ? instr[19:15] : '0;
        uop.rs2     = (writes_reg && !use_imm) ? instr[24:20] : '0;   // unused rs2 reads x0
        uop.rd      = writes_reg ? rd : '0;
        uop.imm     = uop.use_imm ? {{20{instr[31]}}, instr[31:20]} : '0;
    end

endmodule

`default_nettype wire

/* hw/rename.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module rename (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  ooo_pkg::arch_uop_t               uop_in,
    input  wire logic [1:0]                  src_ready,
    input  wire logic                        rob_full,
    input  wire logic [`ROB_W-1:0]           rob_tag,
    input  ooo_pkg::retire_t                 retire,
    output logic                             stall,
    output ooo_pkg::phys_uop_t               uop_out,
    output logic [1:0][`PREG_W-1:0]          src_preg
);

    logic [`PREG_W-1:0] map_table [`ARCH_REGS];
    logic [`PREG_W-1:0] free_list [`ARCH_REGS];
    logic [`AREG_W-1:0] fl_head;
    logic [`AREG_W-1:0] fl_tail;
    logic [`AREG_W:0]   fl_count;

    ooo_pkg::phys_uop_t pend;   // renamed, waiting for its operands
    logic               pend_valid;

    logic go;
    logic accept;
    logic alloc;
    logic release_reg;

    assign go          = pend_valid & ~rob_full & src_ready[0] & src_ready[1];
    // only depends on held state, never on the incoming word
    assign stall       = (pend_valid & ~go) | (fl_count == '0);
    assign accept      = uop_in.valid & ~stall;
    assign alloc       = accept & (uop_in.rd != '0);
    assign release_reg = retire.valid & (retire.rd != '0);

    assign src_preg[0] = pend.prs1;
    assign src_preg[1] = pend.prs2;

    always_comb begin
        uop_out       = pend;
        uop_out.valid = go;
        uop_out.tag   = rob_tag;   // tail entry of the rob
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_valid <= 1'b0;
            fl_head    <= '0;
            fl_tail    <= '0;
            fl_count   <= (`AREG_W+1)'(`ARCH_REGS);
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= `PREG_W'(i);
                free_list[i] <= `PREG_W'(`ARCH_REGS + i);
            end
        end else begin
            if (accept)
                pend_valid <= 1'b1;
            else if (go)
                pend_valid <= 1'b0;
            if (alloc) begin
                map_table[uop_in.rd] <= free_list[fl_head];
                fl_head              <= fl_head + 1'b1;
            end
            if (release_reg) begin
                free_list[fl_tail] <= retire.old_prd;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (alloc && !release_reg)
                fl_count <= fl_count - 1'b1;
            else if (release_reg && !alloc)
                fl_count <= fl_count + 1'b1;
        end
    end

    // sources read the map before this instruction's own rd update
    always_ff @(posedge clk) begin
        if (accept) begin
            pend.valid   <= 1'b1;
            pend.op      <= uop_in.op;
            pend.use_imm <= uop_in.use_imm;
            pend.imm     <= uop_in.imm;
            pend.prs1    <= map_table[uop_in.rs1];
            pend.prs2    <= map_table[uop_in.rs2];
            pend.prd     <= alloc ? free_list[fl_head] : '0;
            pend.ard     <= uop_in.rd;
            pend.old_prd <= map_table[uop_in.rd];
            pend.tag     <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/phys_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module phys_regfile (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [1:0][`PREG_W-1:0] src_preg,
    input  ooo_pkg::phys_uop_t          disp,
    input  ooo_pkg::wb_t                wb,
    output logic [1:0]                  src_ready,
    output logic [`XLEN-1:0]            rs1_value,
    output logic [`XLEN-1:0]            rs2_value
);

    logic [`XLEN-1:0]     regs [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;

    assign src_ready[0] = ready[src_preg[0]];
    assign src_ready[1] = ready[src_preg[1]];

    // p0 is never written, so it reads as zero
    assign rs1_value = regs[disp.prs1];
    assign rs2_value = regs[disp.prs2];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ready <= '1;
            for (int i = 0; i < `PHYS_REGS; i++)
                regs[i] <= '0;
        end else begin
            if (disp.valid && disp.prd != '0)
                ready[disp.prd] <= 1'b0;   // new producer in flight
            if (wb.valid && wb.prd != '0) begin
                regs[wb.prd]  <= wb.value;
                ready[wb.prd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module alu (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  ooo_pkg::phys_uop_t     disp,
    input  wire logic [`XLEN-1:0]  rs1_value,
    input  wire logic [`XLEN-1:0]  rs2_value,
    output ooo_pkg::wb_t           wb
);

    logic               s1_valid;
    ooo_pkg::alu_op_e   s1_op;
    logic [`XLEN-1:0]   s1_a;
    logic [`XLEN-1:0]   s1_b;
    logic [`PREG_W-1:0] s1_prd;
    logic [`ROB_W-1:0]  s1_tag;
    logic [`XLEN-1:0]   result;

    logic               wb_valid;
    logic [`PREG_W-1:0] wb_prd;
    logic [`ROB_W-1:0]  wb_tag;
    logic [`XLEN-1:0]   wb_value;

    always_comb begin
        case (s1_op)
            ooo_pkg::ALU_ADD: result = s1_a + s1_b;
            ooo_pkg::ALU_SUB: result = s1_a - s1_b;
            ooo_pkg::ALU_AND: result = s1_a & s1_b;
            ooo_pkg::ALU_OR:  result = s1_a | s1_b;
            ooo_pkg::ALU_XOR: result = s1_a ^ s1_b;
            default:          result = '0;   // nop
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= disp.valid;
            wb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op  <= disp.op;
        s1_a   <= rs1_value;
        s1_b   <= disp.use_imm ? disp.imm : rs2_value;
        s1_prd <= disp.prd;
        s1_tag <= disp.tag;
        wb_prd   <= s1_prd;
        wb_tag   <= s1_tag;
        wb_value <= result;
    end

    assign wb.valid = wb_valid;
    assign wb.prd   = wb_prd;
    assign wb.tag   = wb_tag;
    assign wb.value = wb_value;

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module reorder_buffer (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  ooo_pkg::phys_uop_t     disp,
    input  ooo_pkg::wb_t           wb,
    output logic                   rob_full,
    output logic [`ROB_W-1:0]      rob_tag,
    output ooo_pkg::retire_t       retire
);

    logic [`AREG_W-1:0]   ent_rd    [`ROB_DEPTH];
    logic [`PREG_W-1:0]   ent_old   [`ROB_DEPTH];
    logic [`XLEN-1:0]     ent_value [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] ent_done;

    logic [`ROB_W-1:0] head;
    logic [`ROB_W-1:0] tail;
    logic [`ROB_W:0]   count;
    logic              do_retire;

    logic               ret_valid;
    logic [`AREG_W-1:0] ret_rd;
    logic [`PREG_W-1:0] ret_old;
    logic [`XLEN-1:0]   ret_value;

    assign rob_full  = (count == (`ROB_W+1)'(`ROB_DEPTH));
    assign rob_tag   = tail;
    assign do_retire = (count != '0) && ent_done[head];   // in order, head only

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_done  <= '0;
            ret_valid <= 1'b0;
        end else begin
            if (disp.valid) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (wb.valid)
                ent_done[wb.tag] <= 1'b1;
            if (do_retire)
                head <= head + 1'b1;
            if (disp.valid && !do_retire)
                count <= count + 1'b1;
            else if (do_retire && !disp.valid)
                count <= count - 1'b1;
            ret_valid <= do_retire;   // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (disp.valid) begin
            ent_rd[tail]  <= disp.ard;
            ent_old[tail] <= disp.old_prd;
        end
        if (wb.valid)
            ent_value[wb.tag] <= wb.value;
        if (do_retire) begin
            ret_rd    <= ent_rd[head];
            ret_old   <= ent_old[head];
            ret_value <= ent_value[head];
        end
    end

    assign retire.valid   = ret_valid;
    assign retire.rd      = ret_rd;
    assign retire.old_prd = ret_old;
    assign retire.value   = ret_value;

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module cpu_core (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic               instr_valid,
    input  wire logic [31:0]        instr,
    output logic                    stall,
    output logic                    retire_valid,
    output logic [`AREG_W-1:0]      retire_rd,
    output logic [`XLEN-1:0]        retire_value
);

    ooo_pkg::arch_uop_t       arch_uop;
    ooo_pkg::phys_uop_t       disp_uop;
    ooo_pkg::wb_t             wb;
    ooo_pkg::retire_t         retire;
    logic [1:0]               src_ready;
    logic [1:0][`PREG_W-1:0]  src_preg;
    logic [`XLEN-1:0]         rs1_value;
    logic [`XLEN-1:0]         rs2_value;
    logic                     rob_full;
    logic [`ROB_W-1:0]        rob_tag;

    decode decode_inst (
        .instr       (instr),
        .instr_valid (instr_valid),
        .uop         (arch_uop)
    );

    rename rename_inst (
        .clk       (clk),
        .rstn      (rstn),
        .uop_in    (arch_uop),
        .src_ready (src_ready),
        .rob_full  (rob_full),
        .rob_tag   (rob_tag),
        .retire    (retire),
        .stall     (stall),
        .uop_out   (disp_uop),
        .src_preg  (src_preg)
    );

    phys_regfile phys_regfile_inst (
        .clk       (clk),
        .rstn      (rstn),
        .src_preg  (src_preg),
        .disp      (disp_uop),
        .wb        (wb),
        .src_ready (src_ready),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    alu alu_inst (
        .clk       (clk),
        .rstn      (rstn),
        .disp      (disp_uop),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb        (wb)
    );

    reorder_buffer reorder_buffer_inst (
        .clk      (clk),
        .rstn     (rstn),
        .disp     (disp_uop),
        .wb       (wb),
        .rob_full (rob_full),
        .rob_tag  (rob_tag),
        .retire   (retire)
    );

    assign retire_valid = retire.valid;
    assign retire_rd    = retire.rd;
    assign retire_value = retire.value;

endmodule

`default_nettype wire

/* dv/cpu_assert.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module cpu_assert (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic               instr_valid,
    input  wire logic               stall,
    input  wire logic               retire_valid,
    input  wire logic [`AREG_W-1:0] retire_rd,
    input  ooo_pkg::arch_uop_t      arch_uop
);

    logic        nop_flag [64];   // one bit per instruction in flight
    logic [5:0]  wr_ptr;
    logic [5:0]  rd_ptr;
    logic [31:0] n_acc;
    logic [31:0] n_ret;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            n_acc  <= '0;
            n_ret  <= '0;
        end else begin
            if (instr_valid && !stall) begin
                nop_flag[wr_ptr] <= (arch_uop.op == ooo_pkg::ALU_NOP);
                wr_ptr           <= wr_ptr + 1'b1;
                n_acc            <= n_acc + 1'b1;
            end
            if (retire_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
                n_ret  <= n_ret + 1'b1;
            end
        end
    end

    quiet_in_reset: assert property (@(posedge clk) !rstn |-> (!stall && !retire_valid))
        else $error("stall or retire_valid high during reset");

    nop_retires_x0: assert property (@(posedge clk) disable iff (!rstn)
        (retire_valid && nop_flag[rd_ptr]) |-> (retire_rd == '0))
        else $error("nop retired with nonzero rd");

    no_extra_retire: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> (n_ret < n_acc))
        else $error("more retirements than accepted instructions");

endmodule

bind cpu_core cpu_assert cpu_assert_inst (
    .clk          (clk),
    .rstn         (rstn),
    .instr_valid  (instr_valid),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .arch_uop     (arch_uop)
);

`default_nettype wire

/* dv/cpu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_checker (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    input  wire logic        stall,
    input  wire logic        retire_valid,
    input  wire logic [4:0]  retire_rd,
    input  wire logic [31:0] retire_value,
    output int               errors,
    output int               accepted,
    output int               retired
);

    logic [31:0] model [32];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    logic [4:0]  row_rd_q [$];   // table expectations, in order
    logic [31:0] row_val_q [$];
    int          row_idx;

    task automatic expect_row(input logic [4:0] rd, input logic [31:0] value);
        row_rd_q.push_back(rd);
        row_val_q.push_back(value);
    endtask

    task automatic model_accept(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0]  rd;
        logic        ok;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model[w[19:15]];
        b   = model[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        ok  = 1'b1;
        res = '0;
        if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd0)
            res = a + b;
        else if (opc == 7'h33 && f7 == 7'h20 && f3 == 3'd0)
            res = a - b;
        else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd7)
            res = a & b;
        else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd6)
            res = a | b;
        else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd4)
            res = a ^ b;
        else if (opc == 7'h13 && f3 == 3'd0)
            res = a + imm;
        else
            ok = 1'b0;
        rd = ok ? w[11:7] : 5'd0;
        if (rd == 5'd0)
            res = '0;   // x0 stays zero
        else
            model[rd] = res;
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(res);
    endtask

    task automatic check_retire;
        logic [4:0]  rd;
        logic [31:0] v;
        if (exp_rd_q.size() == 0) begin
            $display("retirement at %0t without any accepted instruction", $time);
            errors++;
            return;
        end
        rd = exp_rd_q.pop_front();
        v  = exp_val_q.pop_front();
        if (retire_rd !== rd || retire_value !== v) begin
            $display("ERROR at %0t: retirement %0d gave x%0d = %h, model has x%0d = %h",
                     $time, retired, retire_rd, retire_value, rd, v);
            errors++;
        end
        if (row_rd_q.size() != 0) begin
            rd = row_rd_q.pop_front();
            v  = row_val_q.pop_front();
            if (retire_rd !== rd || retire_value !== v) begin
                $display("ERROR at %0t: row %0d retired x%0d = %h, table says x%0d = %h",
                         $time, row_idx, retire_rd, retire_value, rd, v);
                errors++;
            end else begin
                $display("row %0d: x%0d = %h ok", row_idx, rd, v);
            end
            row_idx++;
        end
    endtask

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++)
                model[i] = '0;
            exp_rd_q.delete();
            exp_val_q.delete();
            row_idx  = 0;
            errors   = 0;
            accepted = 0;
            retired  = 0;
        end else begin
            if (instr_valid && !stall) begin
                model_accept(instr);
                accepted++;
            end
            if (retire_valid) begin
                check_retire();
                retired++;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

    localparam int NROWS  = 23;
    localparam int NRAND  = 200;
    localparam int LIMIT  = (NROWS + NRAND) * 8 + 200;
    localparam int CHAIN0 = 10;   // dependent chain rows 10..14
    localparam int CHAIN1 = 14;

    logic        clk;
    logic        rstn;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    int          chk_errors;
    int          accepted;
    int          retired;
    int          tb_errors;
    int          cycles = 0;
    int          chain_stalls;
    logic [31:0] rng;
    logic [31:0] row_instr [$];
    logic [4:0]  row_rd [$];
    logic [31:0] row_val [$];

    cpu_core cpu_core_inst (
        .clk          (clk),
        .rstn         (rstn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    cpu_checker checker_inst (
        .clk          (clk),
        .rstn         (rstn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .errors       (chk_errors),
        .accepted     (accepted),
        .retired      (retired)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, retired %0d of %0d", cycles, retired, accepted);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] random_instr(input logic [31:0] r);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = r[7:3];
        rs1 = {1'b0, r[11:8]};   // narrow sources give many dependencies
        rs2 = {1'b0, r[15:12]};
        case (r[2:0] % 3'd6)
            3'd0:    return r_type(7'h00, 3'd0, rd, rs1, rs2);
            3'd1:    return r_type(7'h20, 3'd0, rd, rs1, rs2);
            3'd2:    return r_type(7'h00, 3'd7, rd, rs1, rs2);
            3'd3:    return r_type(7'h00, 3'd6, rd, rs1, rs2);
            3'd4:    return r_type(7'h00, 3'd4, rd, rs1, rs2);
            default: return i_type(r[31:20], rs1, rd);
        endcase
    endfunction

    task automatic add_row(input logic [31:0] w, input logic [4:0] rd, input logic [31:0] v);
        row_instr.push_back(w);
        row_rd.push_back(rd);
        row_val.push_back(v);
    endtask

    // called right after a rising edge, returns on the accepting edge
    task automatic send_instr(input logic [31:0] w, output logic saw_stall);
        saw_stall = 1'b0;
        instr_valid <= 1'b1;
        instr       <= w;
        do begin
            @(negedge clk);
            if (stall)
                saw_stall = 1'b1;
        end while (stall);
        @(posedge clk);
    endtask

    initial begin
        logic stalled;
        rstn        = 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        tb_errors   = 0;
        chain_stalls = 0;
        rng         = 32'd42975;

        add_row(i_type(12'd100, 5'd0, 5'd1), 5'd1, 32'd100);
        add_row(i_type(12'hff9, 5'd0, 5'd2), 5'd2, 32'hffff_fff9);
        add_row(i_type(12'h7ff, 5'd0, 5'd3), 5'd3, 32'h0000_07ff);
        add_row(r_type(7'h00, 3'd0, 5'd4, 5'd1, 5'd2), 5'd4, 32'd93);
        add_row(r_type(7'h20, 3'd0, 5'd5, 5'd2, 5'd1), 5'd5, 32'hffff_ff95);
        add_row(r_type(7'h00, 3'd7, 5'd6, 5'd3, 5'd2), 5'd6, 32'h0000_07f9);
        add_row(r_type(7'h00, 3'd6, 5'd7, 5'd1, 5'd2), 5'd7, 32'hffff_fffd);
        add_row(r_type(7'h00, 3'd4, 5'd8, 5'd3, 5'd1), 5'd8, 32'h0000_079b);
        add_row(i_type(12'h800, 5'd2, 5'd9), 5'd9, 32'hffff_f7f9);
        add_row(r_type(7'h20, 3'd0, 5'd10, 5'd0, 5'd1), 5'd10, 32'hffff_ff9c);
        add_row(i_type(12'd1, 5'd1, 5'd11), 5'd11, 32'd101);
        add_row(r_type(7'h00, 3'd0, 5'd11, 5'd11, 5'd11), 5'd11, 32'd202);
        add_row(r_type(7'h00, 3'd0, 5'd11, 5'd11, 5'd1), 5'd11, 32'd302);
        add_row(r_type(7'h20, 3'd0, 5'd12, 5'd11, 5'd3), 5'd12, 32'hffff_f92f);
        add_row(r_type(7'h00, 3'd4, 5'd12, 5'd12, 5'd11), 5'd12, 32'hffff_f801);
        add_row(i_type(12'hfff, 5'd0, 5'd13), 5'd13, 32'hffff_ffff);
        add_row(r_type(7'h00, 3'd0, 5'd14, 5'd13, 5'd13), 5'd14, 32'hffff_fffe);
        add_row(r_type(7'h20, 3'd0, 5'd15, 5'd0, 5'd13), 5'd15, 32'd1);
        add_row(i_type(12'd5, 5'd1, 5'd0), 5'd0, 32'd0);
        add_row(r_type(7'h00, 3'd0, 5'd16, 5'd0, 5'd1), 5'd16, 32'd100);
        add_row(32'h0000_0073, 5'd0, 32'd0);   // ecall, unsupported
        add_row(r_type(7'h00, 3'd6, 5'd0, 5'd1, 5'd2), 5'd0, 32'd0);
        add_row(r_type(7'h00, 3'd1, 5'd17, 5'd1, 5'd2), 5'd0, 32'd0);   // sll

        // falling edge resets the flops before the first clock
        #1 rstn = 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (stall || retire_valid)
                tb_errors++;
        end
        rstn = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (stall || retire_valid)
                tb_errors++;
        end
        $display("reset: %s", (tb_errors == 0) ? "ok" : "stall or retire_valid high");

        @(posedge clk);
        for (int i = 0; i < NROWS; i++)
            checker_inst.expect_row(row_rd[i], row_val[i]);
        for (int i = 0; i < NROWS; i++) begin
            send_instr(row_instr[i], stalled);
            if (stalled && i > CHAIN0 && i <= CHAIN1)
                chain_stalls++;
        end
        if (chain_stalls == 0) begin
            $display("dependent chain never raised stall");
            tb_errors++;
        end else begin
            $display("dependent chain: stalled %0d times", chain_stalls);
        end

        for (int i = 0; i < NRAND; i++) begin
            rng = xorshift(rng);
            send_instr(random_instr(rng), stalled);
        end
        instr_valid <= 1'b0;

        do @(negedge clk); while (retired != accepted);
        repeat (5) @(negedge clk);
        if (retired != accepted) begin
            $display("retired %0d but accepted %0d", retired, accepted);
            tb_errors++;
        end
        $display("random stream: %0d instructions sent", NRAND);

        $display("done: accepted %0d, retired %0d, checker errors %0d, other errors %0d",
                 accepted, retired, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hw/ooo_pkg.sv
hw/decode.sv
hw/rename.sv
hw/phys_regfile.sv
hw/alu.sv
hw/reorder_buffer.sv
hw/cpu_core.sv
dv/cpu_assert.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_cpu -f all.f -o Vtb_cpu; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
